/* rfSelfTestPkg.sv */
/*
 * Shared definitions for the register-file self-test engine
 * Fault-mode encoding and test-vector data constants
 */
package rfSelfTestPkg;

  // ----------------------------------------------------------
  // Fault injection
  // ----------------------------------------------------------

  // Each defect breaks exactly one register-file rule
  typedef enum logic [1:0] {
    faultNone          = 2'd0,  // Correct register file
    faultWrEnIgnored   = 2'd1,  // Writes happen with wrEn low
    faultZeroWritable  = 2'd2,  // Register 0 stores data
    faultPort2Follows1 = 2'd3   // Read port 2 uses port 1 address
  } faultModeT;

  // ----------------------------------------------------------
  // Test-vector data
  // ----------------------------------------------------------

  // Vector 1, written to register 2 and read on both ports
  localparam logic [31:0] Case1Data = 32'd42;

  // Vector 2, aimed at register 0, must never read back
  localparam logic [31:0] Case2Data = 32'd12;

  // Vector 3 with enable low to register 30, vector 4 to register 12
  localparam logic [31:0] Case3Data = 32'd30;

  // Walk datum high part, register index fills the low byte
  localparam logic [31:0] WalkPattern = 32'h5a3c_9600;

  // Vectors ahead of the register walk
  localparam int NumFixedVectors = 4;

endpackage

/* rfPortIf.sv */
/*
 * Register-file port bundle
 * Write, two reads and clear, with driver/store/monitor views
 */
`timescale 1ns/1ps

interface rfPortIf #(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 5
);

  logic                 wrEn;     // Write enable
  logic [AddrWidth-1:0] wrAddr;   // Write address
  logic [DataWidth-1:0] wrData;   // Write data
  logic [AddrWidth-1:0] rdAddr1;  // Read port 1 address
  logic [AddrWidth-1:0] rdAddr2;  // Read port 2 address
  logic [DataWidth-1:0] rdData1;  // Read port 1 data, combinational
  logic [DataWidth-1:0] rdData2;  // Read port 2 data, combinational
  logic                 clear;    // Zero every register at the edge

  // Sequencer side
  modport driver (output wrEn, wrAddr, wrData, rdAddr1, rdAddr2, clear);

  // Register file side
  modport store (input wrEn, wrAddr, wrData, rdAddr1, rdAddr2, clear,
                 output rdData1, rdData2);

  // Checker only looks at the read data
  modport monitor (input rdData1, rdData2);

endinterface

/* checkIf.sv */
/*
 * Check bundle from sequencer to checker
 * One-cycle strobe plus expected read data for both ports
 */
`timescale 1ns/1ps

interface checkIf #(
  parameter int DataWidth = 32
);

  logic                 chkValid;  // High for the check cycle of a vector
  logic [DataWidth-1:0] expData1;  // Expected read port 1 data
  logic [DataWidth-1:0] expData2;  // Expected read port 2 data

  // Sequencer drives the expectation
  modport source (output chkValid, expData1, expData2);

  // Checker samples it
  modport sink (input chkValid, expData1, expData2);

endinterface

/* regFile.sv */
/*
 * Two-read, one-write register file under test
 * Synchronous write and clear, combinational reads, selectable defects
 */
`timescale 1ns/1ps

module regFile
  import rfSelfTestPkg::*;
#(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 5
) (
  input  logic      begintest,  // Clock
  input  logic      rstN,
  input  faultModeT faultMode,
  rfPortIf.store    port
);

  localparam int NumRegs = 1 << AddrWidth;

  logic [DataWidth-1:0] regs [NumRegs];  // Storage array
  logic                 wrAllowed;       // Write fires this edge
  logic                 zeroLocked;      // Write targets locked register 0
  logic [AddrWidth-1:0] rdAddr2Eff;      // Address actually used by port 2

  // ----------------------------------------------------------
  // Defect selection
  // ----------------------------------------------------------

  // Normal write needs wrEn, broken one writes every cycle
  assign wrAllowed  = port.wrEn || (faultMode == faultWrEnIgnored);

  // Register 0 is read-only zero unless that rule is broken
  assign zeroLocked = (port.wrAddr == '0) && (faultMode != faultZeroWritable);

  // Port 2 may be miswired onto the port 1 address
  assign rdAddr2Eff = (faultMode == faultPort2Follows1) ? port.rdAddr1 : port.rdAddr2;

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------

  always_ff @(posedge begintest or negedge rstN) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (port.clear) begin  // Clear wins over a write
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (wrAllowed && !zeroLocked) begin
      regs[port.wrAddr] <= port.wrData;
    end
  end

  // Reads are plain array lookups
  assign port.rdData1 = regs[port.rdAddr1];
  assign port.rdData2 = regs[rdAddr2Eff];

  // Register 0 holds zero across every write and clear when healthy
  assert property (@(posedge begintest) disable iff (!rstN)
    (faultMode == faultNone) |->
      ((port.rdAddr1 != '0) || (port.rdData1 == '0)) &&
      ((port.rdAddr2 != '0) || (port.rdData2 == '0)))
    else $error("register 0 read nonzero in correct mode");

endmodule

/* testSequencer.sv */
/*
 * Self-test sequencer
 * Idle/clear/write/check FSM issuing fixed vectors then a register walk
 */
`timescale 1ns/1ps

module testSequencer
  import rfSelfTestPkg::*;
#(
  parameter int DataWidth = 32,
  parameter int AddrWidth = 5
) (
  input  logic    begintest,  // Clock
  input  logic    rstN,
  input  logic    start,      // Run request pulse
  output logic    busy,       // High from accept until results land
  rfPortIf.driver port,
  checkIf.source  chk
);

  // Walk covers registers 1 up to the top one
  localparam int NumVectors = NumFixedVectors + (1 << AddrWidth) - 1;
  localparam int IdxWidth   = $clog2(NumVectors);

  // FSM encoding
  localparam logic [1:0] StIdle  = 2'd0;
  localparam logic [1:0] StClear = 2'd1;
  localparam logic [1:0] StWrite = 2'd2;
  localparam logic [1:0] StCheck = 2'd3;

  logic [1:0]          state;
  logic [IdxWidth-1:0] vecIdx;       // Current vector
  logic                startAccept;  // Start seen while idle
  logic                lastVec;      // Final vector in progress

  logic                 vecWrEn;     // Decoded vector fields
  logic [AddrWidth-1:0] vecWrAddr;
  logic [DataWidth-1:0] vecWrData;
  logic [AddrWidth-1:0] vecRdAddr1;
  logic [AddrWidth-1:0] vecRdAddr2;
  logic [DataWidth-1:0] vecExp1;
  logic [DataWidth-1:0] vecExp2;
  logic [AddrWidth-1:0] walkAddr;    // Register hit by a walk vector
  logic [DataWidth-1:0] walkData;    // Its per-register pattern

  // ----------------------------------------------------------
  // Vector decode
  // ----------------------------------------------------------

  assign walkAddr = AddrWidth'(vecIdx - IdxWidth'(NumFixedVectors - 1));  // Index 4 -> reg 1
  assign walkData = DataWidth'(WalkPattern) | DataWidth'(walkAddr);

  always_comb begin
    // Walk vector unless one of the fixed cases
    vecWrEn    = 1'b1;
    vecWrAddr  = walkAddr;
    vecWrData  = walkData;
    vecRdAddr1 = walkAddr;
    vecRdAddr2 = walkAddr;
    vecExp1    = walkData;
    vecExp2    = walkData;
    case (int'(vecIdx))
      0: begin  // Plain write and read back
        vecWrAddr  = AddrWidth'(2);
        vecWrData  = DataWidth'(Case1Data);
        vecRdAddr1 = AddrWidth'(2);
        vecRdAddr2 = AddrWidth'(2);
        vecExp1    = DataWidth'(Case1Data);
        vecExp2    = DataWidth'(Case1Data);
      end
      1: begin  // Register 0 must stay zero
        vecWrAddr  = '0;
        vecWrData  = DataWidth'(Case2Data);
        vecRdAddr1 = '0;
        vecRdAddr2 = '0;
        vecExp1    = '0;
        vecExp2    = '0;
      end
      2: begin  // Enable low, reg 30 keeps its cleared value
        vecWrEn    = 1'b0;
        vecWrAddr  = AddrWidth'(30);
        vecWrData  = DataWidth'(Case3Data);
        vecRdAddr1 = AddrWidth'(30);
        vecRdAddr2 = AddrWidth'(30);
        vecExp1    = '0;
        vecExp2    = '0;
      end
      3: begin  // Port independence, reg 15 still clear
        vecWrAddr  = AddrWidth'(12);
        vecWrData  = DataWidth'(Case3Data);
        vecRdAddr1 = AddrWidth'(12);
        vecRdAddr2 = AddrWidth'(15);
        vecExp1    = DataWidth'(Case3Data);
        vecExp2    = '0;
      end
      default: ;
    endcase
  end

  // ----------------------------------------------------------
  // Control FSM
  // ----------------------------------------------------------

  assign startAccept = start && !busy;  // Ignored mid-run and while results land
  assign lastVec     = (vecIdx == IdxWidth'(NumVectors - 1));

  always_ff @(posedge begintest or negedge rstN) begin
    if (!rstN) begin
      state  <= StIdle;
      vecIdx <= '0;
      busy   <= 1'b0;
    end else begin
      busy <= startAccept || (state != StIdle);  // Falls one edge after return to idle
      case (state)
        StIdle:  if (startAccept) state <= StClear;
        StClear: begin
          vecIdx <= '0;
          state  <= StWrite;
        end
        StWrite: state <= StCheck;
        StCheck: begin
          if (lastVec) begin
            state <= StIdle;
          end else begin
            vecIdx <= vecIdx + 1'b1;
            state  <= StWrite;
          end
        end
        default: state <= StIdle;
      endcase
    end
  end

  // Read addresses held through write and check cycles
  assign port.clear   = (state == StClear);
  assign port.wrEn    = (state == StWrite) && vecWrEn;
  assign port.wrAddr  = vecWrAddr;
  assign port.wrData  = vecWrData;
  assign port.rdAddr1 = vecRdAddr1;
  assign port.rdAddr2 = vecRdAddr2;

  assign chk.chkValid = (state == StCheck);
  assign chk.expData1 = vecExp1;
  assign chk.expData2 = vecExp2;

  // Check cycle keeps the write cycle's read addresses and never writes
  assert property (@(posedge begintest) disable iff (!rstN)
    chk.chkValid |-> !port.wrEn && $stable(port.rdAddr1) && $stable(port.rdAddr2))
    else $error("check cycle writes or moves its read addresses");

  // Clear only in the cycle after an accepted start
  assert property (@(posedge begintest) disable iff (!rstN)
    port.clear |-> $past(start && !busy))
    else $error("clear without accepted start");

endmodule

/* resultChecker.sv */
/*
 * Result checker
 * Compares read data per check strobe, counts failing vectors, flags end
 */
`timescale 1ns/1ps

module resultChecker
  import rfSelfTestPkg::*;
#(
  parameter int DataWidth   = 32,
  parameter int AddrWidth   = 5,
  localparam int NumVectors = NumFixedVectors + (1 << AddrWidth) - 1,
  localparam int CountWidth = $clog2(NumVectors + 1)
) (
  input  logic                  begintest,  // Clock
  input  logic                  rstN,
  input  logic                  start,
  input  logic                  busy,
  rfPortIf.monitor              port,
  checkIf.sink                  chk,
  output logic                  endTest,    // Level, held until next run
  output logic                  dutPassed,
  output logic [CountWidth-1:0] failCount   // Failing vectors this run
);

  localparam int IdxWidth = $clog2(NumVectors);

  logic [IdxWidth-1:0]  checkCount;  // Checks seen this run
  logic                 lastSeen;    // Final check sampled last edge
  logic                 startAccept;
  logic [DataWidth-1:0] diff1;       // Bit mismatches per port
  logic [DataWidth-1:0] diff2;
  logic                 mismatch;

  assign startAccept = start && !busy;  // Same rule as the sequencer
  assign diff1       = port.rdData1 ^ chk.expData1;
  assign diff2       = port.rdData2 ^ chk.expData2;
  assign mismatch    = (|diff1) || (|diff2);  // Either port counts once

  always_ff @(posedge begintest or negedge rstN) begin
    if (!rstN) begin
      checkCount <= '0;
      lastSeen   <= 1'b0;
      failCount  <= '0;
      endTest    <= 1'b0;
      dutPassed  <= 1'b0;
    end else if (startAccept) begin  // New run drops old verdict
      checkCount <= '0;
      lastSeen   <= 1'b0;
      failCount  <= '0;
      endTest    <= 1'b0;
      dutPassed  <= 1'b0;
    end else begin
      if (chk.chkValid) begin
        checkCount <= checkCount + 1'b1;
        if (mismatch) failCount <= failCount + 1'b1;
        if (checkCount == IdxWidth'(NumVectors - 1)) lastSeen <= 1'b1;
      end
      // Lands on the same edge where busy falls
      if (lastSeen) begin
        lastSeen  <= 1'b0;
        endTest   <= 1'b1;
        dutPassed <= (failCount == '0);
      end
    end
  end

  // Strobes only arrive inside a run
  assert property (@(posedge begintest) disable iff (!rstN)
    chk.chkValid |-> busy)
    else $error("check strobe outside a run");

endmodule

/* rfSelfTest.sv */
/*
 * Register-file self-test top level
 * Sequencer, register file and checker joined by the port and check bundles
 */
`timescale 1ns/1ps

module rfSelfTest
  import rfSelfTestPkg::*;
#(
  parameter int DataWidth   = 32,
  parameter int AddrWidth   = 5,
  localparam int NumVectors = NumFixedVectors + (1 << AddrWidth) - 1,
  localparam int CountWidth = $clog2(NumVectors + 1)
) (
  input  logic                  begintest,  // Clock
  input  logic                  rstN,
  input  logic                  start,      // Pulse to begin a run
  input  faultModeT             faultMode,  // Defect to inject
  output logic                  busy,
  output logic                  endTest,
  output logic                  dutPassed,
  output logic [CountWidth-1:0] failCount
);

  // ----------------------------------------------------------
  // Internal bundles
  // ----------------------------------------------------------

  rfPortIf #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) rfBus ();
  checkIf  #(.DataWidth(DataWidth))                        chkBus ();

  // ----------------------------------------------------------
  // Blocks
  // ----------------------------------------------------------

  testSequencer #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) uTestSequencer (
    .begintest (begintest),
    .rstN      (rstN),
    .start     (start),
    .busy      (busy),
    .port      (rfBus.driver),
    .chk       (chkBus.source)
  );

  regFile #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) uRegFile (
    .begintest (begintest),
    .rstN      (rstN),
    .faultMode (faultMode),
    .port      (rfBus.store)
  );

  resultChecker #(.DataWidth(DataWidth), .AddrWidth(AddrWidth)) uResultChecker (
    .begintest (begintest),
    .rstN      (rstN),
    .start     (start),
    .busy      (busy),     // Accept and end detection
    .port      (rfBus.monitor),
    .chk       (chkBus.sink),
    .endTest   (endTest),
    .dutPassed (dutPassed),
    .failCount (failCount)
  );

endmodule

/* tbRfSelfTest.sv */
/*
 * Table-driven testbench for the register-file self-test engine
 * One run per fault mode, checks verdict, fail count, latency and reset state
 */
`timescale 1ns/1ps

module tbRfSelfTest
  import rfSelfTestPkg::*;
();

  localparam int NumRuns    = 5;
  localparam int NumVectors = NumFixedVectors + 31;  // Fixed cases, then registers 1 to 31
  localparam int RunCycles  = 2 * NumVectors + 2;    // Start sampled until endTest high
  localparam int WaitLimit  = 200;                   // Cycles per wait loop
  localparam logic [31:0] Seed = 32'h90fc_00aa;

  logic       begintest;
  logic       rstN;
  logic       start;
  faultModeT  faultMode;
  logic       busy;
  logic       endTest;
  logic       dutPassed;
  logic [5:0] failCount;

  // ----------------------------------------------------------
  // Run table, one row per run
  // ----------------------------------------------------------

  // Each defect trips exactly one vector, the repeat clean run must pass again
  faultModeT rowFault [NumRuns] = '{faultNone, faultWrEnIgnored, faultZeroWritable,
                                    faultPort2Follows1, faultNone};
  int        rowCount [NumRuns] = '{0, 1, 1, 1, 0};            // Expected failCount
  logic      rowPass  [NumRuns] = '{1'b1, 1'b0, 1'b0, 1'b0, 1'b1};  // Expected dutPassed

  int errorCount;
  int checkCount;
  int timeoutCount;
  int runCycles;  // Rising edges after the one that sampled start

  rfSelfTest #(.DataWidth(32), .AddrWidth(5)) u_rfSelfTest (
    .begintest (begintest),
    .rstN      (rstN),
    .start     (start),
    .faultMode (faultMode),
    .busy      (busy),
    .endTest   (endTest),
    .dutPassed (dutPassed),
    .failCount (failCount)
  );

  always #50 begintest = ~begintest;  // 100 ns period

  // ----------------------------------------------------------
  // Helpers
  // ----------------------------------------------------------

  task automatic compareValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    checkCount++;
    if (actual !== expected) begin
      errorCount++;
      $display("FAILED %s: got 0x%h, expected 0x%h", name, actual, expected);
    end
  endtask

  // All four result outputs at once
  task automatic checkOutputs(input logic expBusy, input logic expEnd,
                              input logic expPass, input int expCount);
    compareValue("busy", busy, expBusy);
    compareValue("endTest", endTest, expEnd);
    compareValue("dutPassed", dutPassed, expPass);
    compareValue("failCount", failCount, expCount);
  endtask

  task automatic nextCycle();
    @(negedge begintest);  // Outputs settled half a period after the edge
    runCycles++;
  endtask

  task automatic waitBusy(input int run);
    int waited;
    waited = 0;
    while (!busy && waited < WaitLimit) begin
      nextCycle();
      waited++;
    end
    if (!busy) begin
      timeoutCount++;
      $display("Timeout in run %0d: busy never rose after the start pulse", run);
    end
  endtask

  task automatic waitEnd(input int run);
    int waited;
    waited = 0;
    while (!endTest && waited < WaitLimit) begin
      nextCycle();
      waited++;
    end
    if (!endTest) begin
      timeoutCount++;
      $display("Timeout in run %0d: endTest never rose", run);
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus
  // ----------------------------------------------------------

  initial begin
    int gap;
    int extraAt;
    begintest    = 1'b0;
    rstN         = 1'b0;
    start        = 1'b0;
    faultMode    = faultNone;
    errorCount   = 0;
    checkCount   = 0;
    timeoutCount = 0;
    runCycles    = 0;
    void'($urandom(Seed));

    // Outputs stay low all through reset
    repeat (10) begin
      @(negedge begintest);
      checkOutputs(1'b0, 1'b0, 1'b0, 0);
    end
    rstN = 1'b1;
    @(negedge begintest);
    checkOutputs(1'b0, 1'b0, 1'b0, 0);

    for (int row = 0; row < NumRuns; row++) begin
      // Idle gap, previous verdict must hold
      gap = 1 + ($urandom % 4);
      repeat (gap) begin
        @(negedge begintest);
        if (row == 0) checkOutputs(1'b0, 1'b0, 1'b0, 0);
        else checkOutputs(1'b0, 1'b1, rowPass[row-1], rowCount[row-1]);
      end

      faultMode = rowFault[row];
      start     = 1'b1;
      nextCycle();
      start     = 1'b0;
      runCycles = 0;  // Edge that sampled start is now behind
      waitBusy(row);
      checkOutputs(1'b1, 1'b0, 1'b0, 0);  // Accept drops the old verdict

      // Extra start somewhere mid-run
      extraAt = 1 + ($urandom % 40);
      repeat (extraAt) begin
        nextCycle();
        compareValue("busy", busy, 1'b1);
      end
      start = 1'b1;
      nextCycle();
      start = 1'b0;
      compareValue("busy", busy, 1'b1);  // Still the same run

      waitEnd(row);
      compareValue("runCycles", runCycles, RunCycles);
      checkOutputs(1'b0, 1'b1, rowPass[row], rowCount[row]);
    end

    $display("Checks: %0d  errors: %0d  timeouts: %0d", checkCount, errorCount, timeoutCount);
    if (errorCount == 0 && timeoutCount == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* list.f */
rfSelfTestPkg.sv
rfPortIf.sv
checkIf.sv
regFile.sv
testSequencer.sv
resultChecker.sv
rfSelfTest.sv
tbRfSelfTest.sv

/* run.sh */
#!/bin/sh
# Build and run the register-file self-test testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
  --top-module tbRfSelfTest -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simv > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "TESTBENCH FAILED" "$LOG"; then
  exit 1
fi
exit 0
